// ==== dnc_dims_pkg.sv ====
// Fixed dimensions and Q8.8 number format of the read unit
// Index widths come from $clog2, so every dimension must be 2 or more
// Changing a size needs a full rebuild of every file that imports this package
package dnc_dims_pkg;

  ////////////////////////////////////////////////////////////
  // Matrix dimensions
  ////////////////////////////////////////////////////////////

  localparam int MEM_LOCATIONS = 4;  // N, memory rows
  localparam int WORD_ELEMS    = 4;  // W, elements per row
  localparam int READ_HEADS    = 2;  // R, read heads

  // Operand buffer sizes
  localparam int MEM_DEPTH    = MEM_LOCATIONS * WORD_ELEMS;
  localparam int WEIGHT_DEPTH = READ_HEADS * MEM_LOCATIONS;

  // Index widths
  localparam int LOC_BITS          = $clog2(MEM_LOCATIONS);
  localparam int ELEM_BITS         = $clog2(WORD_ELEMS);
  localparam int HEAD_BITS         = $clog2(READ_HEADS);
  localparam int MEM_INDEX_BITS    = $clog2(MEM_DEPTH);
  localparam int WEIGHT_INDEX_BITS = $clog2(WEIGHT_DEPTH);

  ////////////////////////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////////////////////////

  localparam int WORD_BITS  = 16;  // Signed Q8.8
  localparam int FRAC_BITS  = 8;
  localparam int ACC_BITS   = 40;  // Q16.16 plus guard bits
  localparam int ROUND_HALF = 2 ** (FRAC_BITS - 1);
  localparam int WORD_MAX   = 2 ** (WORD_BITS - 1) - 1;
  localparam int WORD_MIN   = -(2 ** (WORD_BITS - 1));

endpackage

// ==== dnc_types_pkg.sv ====
// Word types and packed records passed between controller, streamer and testbench
// Field widths follow the sizes in the dimensions package
package dnc_types_pkg;

  import dnc_dims_pkg::*;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////

  // One data word, signed Q8.8
  typedef logic signed [WORD_BITS-1:0] dnc_word_t;

  // Accumulator, signed Q16.16 with headroom for N products
  typedef logic signed [ACC_BITS-1:0] dnc_acc_t;

  // Loop indices
  typedef logic [HEAD_BITS-1:0] head_idx_t;
  typedef logic [ELEM_BITS-1:0] elem_idx_t;
  typedef logic [LOC_BITS-1:0]  loc_idx_t;

  ////////////////////////////////////////////////////////////
  // Records
  ////////////////////////////////////////////////////////////

  // Full-precision sum of one (i,k) pair, controller to streamer
  typedef struct packed {
    head_idx_t i;
    elem_idx_t k;
    dnc_acc_t  acc;
  } read_sum_t;

  // Rounded read vector element, as seen at the top level
  typedef struct packed {
    head_idx_t i;
    elem_idx_t k;
    dnc_word_t value;
  } read_elem_t;

endpackage

// ==== dnc_operand_buffer.sv ====
// Operand store filled in arrival order, one element per load strobe
// Strobes beyond DEPTH are dropped until clear empties the buffer
// Contents are not reset, only the fill count
`timescale 1ns/1ps

module dnc_operand_buffer #(
  parameter type ELEM_T = logic [15:0],
  parameter int  DEPTH  = 16
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     clear,
  input  logic                     load,
  input  ELEM_T                    load_data,
  input  logic [$clog2(DEPTH)-1:0] rd_index,
  output ELEM_T                    rd_data,
  output logic                     full
);

  ////////////////////////////////////////////////////////////
  // Local sizes and storage
  ////////////////////////////////////////////////////////////

  localparam int IDX_BITS   = $clog2(DEPTH);
  localparam int COUNT_BITS = $clog2(DEPTH + 1);

  // Element storage
  ELEM_T mem_q [DEPTH];

  // Number of elements held, also the next write slot
  logic [COUNT_BITS-1:0] count_q;

  // Write accepted this cycle
  logic wr_en;

  ////////////////////////////////////////////////////////////
  // Fill control
  ////////////////////////////////////////////////////////////

  assign full  = (count_q == COUNT_BITS'(DEPTH));
  // Clear takes priority over a load in the same cycle
  assign wr_en = load && !full && !clear;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      count_q <= '0;
    end else if (clear) begin
      count_q <= '0;
    end else if (wr_en) begin
      count_q <= count_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage write and read
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem_q[count_q[IDX_BITS-1:0]] <= load_data;
    end
  end

  // Combinational read for the controller
  assign rd_data = mem_q[rd_index];

endmodule

// ==== dnc_read_vectors.sv ====
// Controller and MAC for r(i,k) = sum over j of M(j,k) * w(i,j)
// One product per cycle, N cycles per pair plus one cycle to issue the sum
// Operands must be fully loaded before accumulation begins
// start is ignored outside idle
`timescale 1ns/1ps

module dnc_read_vectors (
  input  logic                                        CLK,
  input  logic                                        RST,
  input  logic                                        start,
  input  logic                                        mem_full,
  input  logic                                        weight_full,
  input  dnc_types_pkg::dnc_word_t                    mem_data,
  input  dnc_types_pkg::dnc_word_t                    weight_data,
  output logic [dnc_dims_pkg::MEM_INDEX_BITS-1:0]     mem_index,
  output logic [dnc_dims_pkg::WEIGHT_INDEX_BITS-1:0]  weight_index,
  output logic                                        clear,
  output logic                                        sum_valid,
  output dnc_types_pkg::read_sum_t                    sum,
  output logic                                        last_sum
);

  import dnc_dims_pkg::*;
  import dnc_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // FSM and loop state
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_OPERANDS,
    ST_ACCUMULATE,
    ST_ISSUE
  } state_t;

  state_t state_q;

  // Loop counters, i outer, k middle, j inner
  head_idx_t i_q;
  elem_idx_t k_q;
  loc_idx_t  j_q;

  // Running sum of the current pair
  dnc_acc_t acc_q;
  dnc_acc_t product;

  logic operands_ready;
  logic last_loc;
  logic last_elem;
  logic last_pair;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Both buffers full and not being emptied by the previous run
  assign operands_ready = mem_full && weight_full && !clear;

  assign last_loc  = (j_q == loc_idx_t'(MEM_LOCATIONS - 1));
  assign last_elem = (k_q == elem_idx_t'(WORD_ELEMS - 1));
  assign last_pair = last_elem && (i_q == head_idx_t'(READ_HEADS - 1));

  // Memory is row-major, M(j,k) at j*W + k
  assign mem_index    = MEM_INDEX_BITS'(j_q * WORD_ELEMS + k_q);
  // Weighting is head-major, w(i,j) at i*N + j
  assign weight_index = WEIGHT_INDEX_BITS'(i_q * MEM_LOCATIONS + j_q);

  // Q8.8 times Q8.8 gives Q16.16, sign-extended to accumulator width
  always_comb begin
    product = mem_data * weight_data;
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q   <= ST_IDLE;
      i_q       <= '0;
      k_q       <= '0;
      j_q       <= '0;
      acc_q     <= '0;
      sum_valid <= 1'b0;
      last_sum  <= 1'b0;
      clear     <= 1'b0;
    end else begin
      // Strobes default low
      sum_valid <= 1'b0;
      last_sum  <= 1'b0;
      // Buffers are emptied one cycle after the final sum
      clear     <= last_sum;

      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= operands_ready ? ST_ACCUMULATE : ST_WAIT_OPERANDS;
          end
        end

        ST_WAIT_OPERANDS: begin
          if (operands_ready) begin
            state_q <= ST_ACCUMULATE;
          end
        end

        ST_ACCUMULATE: begin
          acc_q <= acc_q + product;
          if (last_loc) begin
            j_q     <= '0;
            state_q <= ST_ISSUE;
          end else begin
            j_q <= j_q + 1'b1;
          end
        end

        ST_ISSUE: begin
          sum_valid <= 1'b1;
          acc_q     <= '0;
          if (last_pair) begin
            last_sum <= 1'b1;
            i_q      <= '0;
            k_q      <= '0;
            state_q  <= ST_IDLE;
          end else begin
            // Next element of the same head, or first element of the next head
            if (last_elem) begin
              k_q <= '0;
              i_q <= i_q + 1'b1;
            end else begin
              k_q <= k_q + 1'b1;
            end
            state_q <= ST_ACCUMULATE;
          end
        end

        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Sum payload
  ////////////////////////////////////////////////////////////

  // Captured alongside sum_valid, held otherwise
  always_ff @(posedge CLK) begin
    if (state_q == ST_ISSUE) begin
      sum.i   <= i_q;
      sum.k   <= k_q;
      sum.acc <= acc_q;
    end
  end

endmodule

// ==== dnc_read_streamer.sv ====
// Output stage, Q16.16 sum to Q8.8 with round half up and saturation
// One register cycle from sum_valid to r_out_k_enable, no stall possible
// ready follows the last element by one cycle
`timescale 1ns/1ps

module dnc_read_streamer (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      sum_valid,
  input  dnc_types_pkg::read_sum_t  sum,
  input  logic                      last_sum,
  output logic                      r_out_k_enable,
  output logic                      r_out_i_enable,
  output dnc_types_pkg::read_elem_t r_out,
  output logic                      ready
);

  import dnc_dims_pkg::*;
  import dnc_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // Rounding and saturation
  ////////////////////////////////////////////////////////////

  dnc_acc_t  rounded;
  dnc_acc_t  shifted;
  dnc_word_t sat_word;

  // last_sum lined up with the final element
  logic last_q;

  always_comb begin
    // Half an output step, then drop the extra fraction bits
    rounded = sum.acc + dnc_acc_t'(ROUND_HALF);
    // Arithmetic shift keeps the sign
    shifted = rounded >>> FRAC_BITS;

    // Clamp to the signed word range
    if (shifted > dnc_acc_t'(WORD_MAX)) begin
      sat_word = dnc_word_t'(WORD_MAX);
    end else if (shifted < dnc_acc_t'(WORD_MIN)) begin
      sat_word = dnc_word_t'(WORD_MIN);
    end else begin
      sat_word = shifted[WORD_BITS-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Output strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      r_out_k_enable <= 1'b0;
      r_out_i_enable <= 1'b0;
      last_q         <= 1'b0;
      ready          <= 1'b0;
    end else begin
      r_out_k_enable <= sum_valid;
      // Head strobe marks the first element of each head
      r_out_i_enable <= sum_valid && (sum.k == '0);
      // Final element leaves a cycle after last_sum, ready one cycle after that
      last_q         <= last_sum;
      ready          <= last_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output element
  ////////////////////////////////////////////////////////////

  // Holds the last element between strobes
  always_ff @(posedge CLK) begin
    if (sum_valid) begin
      r_out.i     <= sum.i;
      r_out.k     <= sum.k;
      r_out.value <= sat_word;
    end
  end

endmodule

// ==== dnc_read_unit.sv ====
// Read vector unit of a DNC memory, operands streamed in, r(i,k) streamed out
// Load memory row-major and weightings head-major, then pulse start
// Loads for the next run are taken only after ready
`timescale 1ns/1ps

module dnc_read_unit (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  logic                      m_in_enable,
  input  dnc_types_pkg::dnc_word_t  m_in,
  input  logic                      w_in_enable,
  input  dnc_types_pkg::dnc_word_t  w_in,
  output logic                      ready,
  output logic                      r_out_k_enable,
  output logic                      r_out_i_enable,
  output dnc_types_pkg::read_elem_t r_out
);

  import dnc_dims_pkg::*;
  import dnc_types_pkg::*;

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////

  // Buffer read ports
  logic [MEM_INDEX_BITS-1:0]    mem_index;
  logic [WEIGHT_INDEX_BITS-1:0] weight_index;
  dnc_word_t                    mem_data;
  dnc_word_t                    weight_data;
  logic                         mem_full;
  logic                         weight_full;

  // End-of-run empty pulse to both buffers
  logic clear;

  // Controller to streamer
  logic      sum_valid;
  read_sum_t sum;
  logic      last_sum;

  ////////////////////////////////////////////////////////////
  // Operand buffers
  ////////////////////////////////////////////////////////////

  // Memory matrix M, N x W
  dnc_operand_buffer #(
    .ELEM_T (dnc_word_t),
    .DEPTH  (MEM_DEPTH)
  ) i_mem_buffer (
    .CLK       (CLK),
    .RST       (RST),
    .clear     (clear),
    .load      (m_in_enable),
    .load_data (m_in),
    .rd_index  (mem_index),
    .rd_data   (mem_data),
    .full      (mem_full)
  );

  // Read weightings w, R x N
  dnc_operand_buffer #(
    .ELEM_T (dnc_word_t),
    .DEPTH  (WEIGHT_DEPTH)
  ) i_weight_buffer (
    .CLK       (CLK),
    .RST       (RST),
    .clear     (clear),
    .load      (w_in_enable),
    .load_data (w_in),
    .rd_index  (weight_index),
    .rd_data   (weight_data),
    .full      (weight_full)
  );

  ////////////////////////////////////////////////////////////
  // Controller and output stage
  ////////////////////////////////////////////////////////////

  dnc_read_vectors i_read_vectors (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .mem_full     (mem_full),
    .weight_full  (weight_full),
    .mem_data     (mem_data),
    .weight_data  (weight_data),
    .mem_index    (mem_index),
    .weight_index (weight_index),
    .clear        (clear),
    .sum_valid    (sum_valid),
    .sum          (sum),
    .last_sum     (last_sum)
  );

  dnc_read_streamer i_read_streamer (
    .CLK            (CLK),
    .RST            (RST),
    .sum_valid      (sum_valid),
    .sum            (sum),
    .last_sum       (last_sum),
    .r_out_k_enable (r_out_k_enable),
    .r_out_i_enable (r_out_i_enable),
    .r_out          (r_out),
    .ready          (ready)
  );

endmodule

// ==== tb_clock_gen.sv ====
// Free-running testbench clock, 20 ns period
// Reset is high from time zero and released after 16 rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  // Release lands just after a rising edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

// ==== dnc_read_unit_asserts.sv ====
// Output timing rules of the read unit, checked only out of reset
// Bound to dnc_read_unit, failures are counted in fail_count
`timescale 1ns/1ps

module dnc_read_unit_asserts (
  input logic CLK,
  input logic RST,
  input logic ready,
  input logic r_out_k_enable,
  input logic r_out_i_enable
);

  // Number of failed assertions so far
  int fail_count = 0;

  // Head strobe only travels with an element
  a_head_with_elem: assert property (
    @(posedge CLK) disable iff (RST) r_out_i_enable |-> r_out_k_enable
  ) else begin
    fail_count++;
    $error("r_out_i_enable high without r_out_k_enable");
  end

  // ready is a single-cycle pulse
  a_ready_single: assert property (
    @(posedge CLK) disable iff (RST) ready |=> !ready
  ) else begin
    fail_count++;
    $error("ready high for two cycles in a row");
  end

  // Nothing streams out once the run has ended
  a_quiet_after_ready: assert property (
    @(posedge CLK) disable iff (RST) ready |=> !r_out_k_enable
  ) else begin
    fail_count++;
    $error("r_out_k_enable in the cycle after ready");
  end

endmodule

// ==== tb_dnc_read_unit.sv ====
// Directed tests of the DNC read unit against a golden model of r(i,k)
// Operands come from a 16-bit Fibonacci LFSR seeded with 41
// Inputs change on the rising edge, outputs are read at that edge before they update
`timescale 1ns/1ps

module tb_dnc_read_unit;

  import dnc_dims_pkg::*;
  import dnc_types_pkg::*;

  localparam int ELEM_COUNT     = READ_HEADS * WORD_ELEMS;
  localparam int RESULT_TIMEOUT = 100;
  localparam int RESET_TIMEOUT  = 100;

  logic       CLK;
  logic       RST;
  logic       start;
  logic       m_in_enable;
  dnc_word_t  m_in;
  logic       w_in_enable;
  dnc_word_t  w_in;
  logic       ready;
  logic       r_out_k_enable;
  logic       r_out_i_enable;
  read_elem_t r_out;

  // Operands of the current run, same layout as the load streams
  dnc_word_t  mem_op    [MEM_DEPTH];
  dnc_word_t  weight_op [WEIGHT_DEPTH];
  // Expected output, index i*W + k
  read_elem_t expected  [ELEM_COUNT];
  logic [15:0] lfsr_q;

  tb_clock_gen i_clock_gen (
    .CLK (CLK),
    .RST (RST)
  );

  dnc_read_unit i_dut (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .m_in_enable    (m_in_enable),
    .m_in           (m_in),
    .w_in_enable    (w_in_enable),
    .w_in           (w_in),
    .ready          (ready),
    .r_out_k_enable (r_out_k_enable),
    .r_out_i_enable (r_out_i_enable),
    .r_out          (r_out)
  );

  bind dnc_read_unit dnc_read_unit_asserts i_asserts (
    .CLK            (CLK),
    .RST            (RST),
    .ready          (ready),
    .r_out_k_enable (r_out_k_enable),
    .r_out_i_enable (r_out_i_enable)
  );

  ////////////////////////////////////////////////////////////
  // Reporting and compares
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string text);
    $display("%s", text);
    $display("Simulation failed");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic compare_elem(input read_elem_t got, input read_elem_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf(
        "ERROR at %0t: %s got i=%0d k=%0d value=%h, expected i=%0d k=%0d value=%h",
        $time, what, got.i, got.k, got.value, exp.i, exp.k, exp.value));
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // LFSR and golden model
  ////////////////////////////////////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = (value << 1) | lfsr_q[0];
    end
  endtask

  // Signed operands of the given bit width, centred on zero
  task automatic fill_random_operands(input int bits);
    int v;
    for (int n = 0; n < MEM_DEPTH; n++) begin
      draw_bits(bits, v);
      mem_op[n] = dnc_word_t'(v - (1 << (bits - 1)));
    end
    for (int n = 0; n < WEIGHT_DEPTH; n++) begin
      draw_bits(bits, v);
      weight_op[n] = dnc_word_t'(v - (1 << (bits - 1)));
    end
  endtask

  // Exact sum in Q16.16, round half up, then clamp to Q8.8
  function automatic dnc_word_t golden_value(input int i, input int k);
    longint total;
    longint scaled;
    total = 0;
    for (int j = 0; j < MEM_LOCATIONS; j++) begin
      total += longint'(mem_op[j * WORD_ELEMS + k]) * longint'(weight_op[i * MEM_LOCATIONS + j]);
    end
    scaled = (total + (longint'(1) <<< (FRAC_BITS - 1))) >>> FRAC_BITS;
    if (scaled > 32767) begin
      return 16'sh7FFF;
    end
    if (scaled < -32768) begin
      return 16'sh8000;
    end
    return dnc_word_t'(scaled);
  endfunction

  task automatic set_expected(input int i, input int k, input dnc_word_t value);
    expected[i * WORD_ELEMS + k].i     = head_idx_t'(i);
    expected[i * WORD_ELEMS + k].k     = elem_idx_t'(k);
    expected[i * WORD_ELEMS + k].value = value;
  endtask

  task automatic expect_golden();
    for (int i = 0; i < READ_HEADS; i++) begin
      for (int k = 0; k < WORD_ELEMS; k++) begin
        set_expected(i, k, golden_value(i, k));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers and output collection
  ////////////////////////////////////////////////////////////

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    @(posedge CLK);
    while (RST) begin
      @(posedge CLK);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        report_failure("Timed out waiting for reset to be released");
      end
    end
  endtask

  // Row-major, j outer and k inner
  task automatic load_memory();
    for (int n = 0; n < MEM_DEPTH; n++) begin
      @(posedge CLK);
      m_in_enable <= 1'b1;
      m_in        <= mem_op[n];
    end
    @(posedge CLK);
    m_in_enable <= 1'b0;
  endtask

  // Head-major, i outer and j inner
  task automatic load_weights();
    for (int n = 0; n < WEIGHT_DEPTH; n++) begin
      @(posedge CLK);
      w_in_enable <= 1'b1;
      w_in        <= weight_op[n];
    end
    @(posedge CLK);
    w_in_enable <= 1'b0;
  endtask

  // Garbage strobes into both full buffers
  task automatic send_extra_loads(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge CLK);
      m_in_enable <= 1'b1;
      m_in        <= dnc_word_t'(16'h5A5A);
      w_in_enable <= 1'b1;
      w_in        <= dnc_word_t'(16'hA5A5);
    end
    @(posedge CLK);
    m_in_enable <= 1'b0;
    w_in_enable <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // Elements in i-outer, k-inner order, N+1 cycles apart
  // ready comes alone in the cycle after the last element
  task automatic collect_results();
    int   count;
    int   waited;
    logic done;
    logic prev_k_enable;
    count         = 0;
    waited        = 0;
    done          = 1'b0;
    prev_k_enable = 1'b0;
    while (!done) begin
      @(posedge CLK);
      waited++;
      if (r_out_k_enable) begin
        if (count >= ELEM_COUNT) begin
          report_failure("More read elements arrived than the run produces");
        end
        if (count > 0) begin
          compare_flag(logic'(waited == MEM_LOCATIONS + 1), 1'b1, "element spacing of N+1");
        end
        compare_flag(r_out_i_enable, logic'(expected[count].k == 0), "r_out_i_enable");
        compare_elem(r_out, expected[count], "r_out");
        count++;
        waited = 0;
      end else begin
        compare_flag(r_out_i_enable, 1'b0, "r_out_i_enable without element");
      end
      if (ready) begin
        compare_flag(logic'(count == ELEM_COUNT), 1'b1, "all elements received by ready");
        compare_flag(r_out_k_enable, 1'b0, "r_out_k_enable together with ready");
        compare_flag(prev_k_enable, 1'b1, "read element in the cycle before ready");
        done = 1'b1;
      end else if (waited > RESULT_TIMEOUT) begin
        report_failure("Timed out waiting for a read element or ready");
      end
      prev_k_enable = r_out_k_enable;
    end
    @(posedge CLK);
    compare_flag(ready, 1'b0, "ready after its pulse");
    compare_flag(r_out_k_enable, 1'b0, "r_out_k_enable after ready");
  endtask

  task automatic run_current_operands();
    load_memory();
    load_weights();
    pulse_start();
    collect_results();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_stays_quiet();
    repeat (20) begin
      @(posedge CLK);
      compare_flag(ready, 1'b0, "ready after reset");
      compare_flag(r_out_k_enable, 1'b0, "r_out_k_enable after reset");
      compare_flag(r_out_i_enable, 1'b0, "r_out_i_enable after reset");
    end
  endtask

  // w(i,j) = 1.0 at j = i+1 picks memory row i+1 exactly
  task automatic one_hot_selects_rows();
    fill_random_operands(16);
    for (int i = 0; i < READ_HEADS; i++) begin
      for (int j = 0; j < MEM_LOCATIONS; j++) begin
        weight_op[i * MEM_LOCATIONS + j] = (j == i + 1) ? 16'sh0100 : 16'sh0000;
      end
      for (int k = 0; k < WORD_ELEMS; k++) begin
        set_expected(i, k, mem_op[(i + 1) * WORD_ELEMS + k]);
      end
    end
    run_current_operands();
  endtask

  // Operands within +-2.0
  task automatic random_matches_golden();
    fill_random_operands(10);
    expect_golden();
    run_current_operands();
  endtask

  // Columns 0..2 near +127 saturate, column 3 holds one LSB at weight 0.5
  task automatic saturation_and_rounding();
    for (int j = 0; j < MEM_LOCATIONS; j++) begin
      for (int k = 0; k < WORD_ELEMS; k++) begin
        if (k < WORD_ELEMS - 1) begin
          mem_op[j * WORD_ELEMS + k] = dnc_word_t'(16'sh7F00 + j);
        end else begin
          mem_op[j * WORD_ELEMS + k] = (j == 0) ? 16'sh0001 : 16'sh0000;
        end
      end
      weight_op[j]                 = (j == 0) ? 16'sh0080 : 16'sh0100;
      weight_op[MEM_LOCATIONS + j] = (j == 0) ? 16'shFF80 : 16'shFF00;
    end
    for (int k = 0; k < WORD_ELEMS - 1; k++) begin
      set_expected(0, k, 16'sh7FFF);
      set_expected(1, k, 16'sh8000);
    end
    // +0.5 LSB rounds up to 1, -0.5 LSB rounds up to 0
    set_expected(0, WORD_ELEMS - 1, 16'sh0001);
    set_expected(1, WORD_ELEMS - 1, 16'sh0000);
    run_current_operands();
  endtask

  task automatic start_before_loading();
    fill_random_operands(10);
    expect_golden();
    load_memory();
    pulse_start();
    // Controller waits for the weightings, nothing may come out
    repeat (10) begin
      @(posedge CLK);
      compare_flag(r_out_k_enable, 1'b0, "r_out_k_enable before weights loaded");
      compare_flag(ready, 1'b0, "ready before weights loaded");
    end
    load_weights();
    send_extra_loads(3);
    collect_results();
  endtask

  // Back-to-back runs, new operands load right after ready
  task automatic second_run_after_ready();
    fill_random_operands(10);
    expect_golden();
    run_current_operands();
    fill_random_operands(10);
    expect_golden();
    run_current_operands();
  endtask

  initial begin
    start       = 1'b0;
    m_in_enable = 1'b0;
    m_in        = '0;
    w_in_enable = 1'b0;
    w_in        = '0;
    lfsr_q      = 16'd41;
    wait_reset_release();
    reset_stays_quiet();
    one_hot_selects_rows();
    random_matches_golden();
    saturation_and_rounding();
    start_before_loading();
    second_run_after_ready();
    repeat (4) @(posedge CLK);
    if (i_dut.i_asserts.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      report_failure("An output timing assertion failed during the run");
    end
  end

endmodule

// ==== vlog.f ====
dnc_dims_pkg.sv
dnc_types_pkg.sv
dnc_operand_buffer.sv
dnc_read_vectors.sv
dnc_read_streamer.sv
dnc_read_unit.sv
tb_clock_gen.sv
dnc_read_unit_asserts.sv
tb_dnc_read_unit.sv
